// File: store_unit_settings.svh
// ----------------------------------------------------------------------
// Global widths and queue depths of the store unit
// Both queue depths must be powers of two and at least 2
// Translation is always present, XLEN is fixed at 64
// ----------------------------------------------------------------------
`ifndef STORE_UNIT_SETTINGS_SVH
`define STORE_UNIT_SETTINGS_SVH

// Virtual address width (Sv39)
`define SU_VLEN 39

// Physical address width
`define SU_PLEN 56

// Data path width, the byte enable is XLEN/8 wide
`define SU_XLEN 64

// Width of the issue-stage transaction ID
`define SU_TRANS_ID_BITS 3

// Entries in the speculative and the commit queue
`define SU_SPEC_DEPTH 4
`define SU_COMMIT_DEPTH 4

`endif

// File: store_unit_pkg.sv
// ----------------------------------------------------------------------
// Types shared by the store unit and its testbench
// Field widths come from the settings header
// The exception cause and tval are XLEN wide
// ----------------------------------------------------------------------
`include "store_unit_settings.svh"

package store_unit_pkg;

  // Transfer size of one store
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_e;

  // ------------------------------------------------------------------
  // Issue side
  // ------------------------------------------------------------------
  // Store request as handed over by the issue stage
  typedef struct packed {
    logic [`SU_VLEN-1:0]          vaddr;
    logic [`SU_XLEN-1:0]          data;
    logic [`SU_XLEN/8-1:0]        be;
    size_e                        size;
    logic [`SU_TRANS_ID_BITS-1:0] trans_id;
  } store_req_t;

  // Translation exception from the MMU
  typedef struct packed {
    logic                valid;
    logic [`SU_XLEN-1:0] cause;
    logic [`SU_XLEN-1:0] tval;
  } store_ex_t;

  // Result returned to the issue stage
  typedef struct packed {
    logic [`SU_TRANS_ID_BITS-1:0] trans_id;
    logic [`SU_XLEN-1:0]          result;
    store_ex_t                    ex;
  } store_result_t;

  // ------------------------------------------------------------------
  // Store buffer and memory side
  // ------------------------------------------------------------------
  // One store buffer slot, data already rotated to the address offset
  typedef struct packed {
    logic [`SU_PLEN-1:0]   paddr;
    logic [`SU_XLEN-1:0]   data;
    logic [`SU_XLEN/8-1:0] be;
    size_e                 size;
  } store_entry_t;

  // Write request on the data-memory port
  typedef struct packed {
    logic [`SU_PLEN-1:0]   paddr;
    logic [`SU_XLEN-1:0]   data;
    logic [`SU_XLEN/8-1:0] be;
  } mem_wr_t;

endpackage

// File: store_queue_cnt.sv
// ----------------------------------------------------------------------
// Pointer and occupancy tracker for one circular queue
// DEPTH must be a power of two and at least 2, pointers wrap naturally
// Push on full or pop on empty is not guarded here
// ----------------------------------------------------------------------
module store_queue_cnt #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     push_i,
  input  logic                     pop_i,
  output logic [$clog2(DEPTH)-1:0] wr_ptr_o,
  output logic [$clog2(DEPTH)-1:0] rd_ptr_o,
  output logic                     full_o,
  output logic                     empty_o
);

  localparam int unsigned AW = $clog2(DEPTH);

  logic [AW-1:0] wr_ptr_q, rd_ptr_q;
  // One extra bit so that DEPTH itself fits
  logic [AW:0]   cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign wr_ptr_o = wr_ptr_q;
  assign rd_ptr_o = rd_ptr_q;
  assign full_o   = (cnt_q == (AW+1)'(DEPTH));
  assign empty_o  = (cnt_q == '0);

endmodule

// File: store_ctrl_fsm.sv
// ----------------------------------------------------------------------
// Store control FSM
// paddr_i and ex_i are taken to belong to the store in VALID_STORE
// A waiting request must stay on valid_i until it is popped
// Exception and flush outrank every other decision
// ----------------------------------------------------------------------
module store_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic valid_i,
  input  logic dtlb_hit_i,
  input  logic ex_valid_i,
  input  logic st_ready_i,
  output logic pop_st_o,
  output logic valid_o,
  output logic translation_req_o,
  output logic st_valid_o,
  output logic st_valid_nf_o,
  output logic capture_o
);

  typedef enum logic [1:0] {
    IDLE,
    VALID_STORE,
    WAIT_TRANSLATION,
    WAIT_STORE_READY
  } state_e;

  state_e state_d, state_q;

  // ------------------------------------------------------------------
  // Next state and outputs
  // ------------------------------------------------------------------
  always_comb begin : store_control
    state_d           = state_q;
    pop_st_o          = 1'b0;
    valid_o           = 1'b0;
    translation_req_o = 1'b0;
    st_valid_o        = 1'b0;
    st_valid_nf_o     = 1'b0;

    case (state_q)
      IDLE, VALID_STORE: begin
        // Second cycle of the previous store, post it to the buffer
        if (state_q == VALID_STORE) begin
          valid_o       = 1'b1;
          st_valid_o    = !flush_i;
          st_valid_nf_o = 1'b1;
          state_d       = IDLE;
        end
        // New request, translate and take it if nothing stalls
        if (valid_i) begin
          translation_req_o = 1'b1;
          if (!st_ready_i) begin
            state_d = WAIT_STORE_READY;
          end else if (!dtlb_hit_i) begin
            state_d = WAIT_TRANSLATION;
          end else begin
            pop_st_o = 1'b1;
            state_d  = VALID_STORE;
          end
        end
      end

      // Buffer full, keep translating until space and a hit are there
      WAIT_STORE_READY: begin
        translation_req_o = 1'b1;
        if (st_ready_i && dtlb_hit_i) begin
          state_d = IDLE;
        end
      end

      // TLB miss, buffer space was there when we got here
      default: begin
        translation_req_o = 1'b1;
        if (dtlb_hit_i) begin
          state_d = IDLE;
        end
      end
    endcase

    // Translation exception ends the instruction without a store
    if (ex_valid_i && (state_q != IDLE)) begin
      pop_st_o   = 1'b1;
      valid_o    = 1'b1;
      st_valid_o = 1'b0;
      state_d    = IDLE;
    end

    if (flush_i) begin
      state_d = IDLE;
    end
  end

  // Aligner follows whatever request is being translated
  assign capture_o = translation_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: store_data_align.sv
// ----------------------------------------------------------------------
// Store data re-aligner
// Rotation uses vaddr[2:0] only, the byte enable is passed as given
// Outputs hold the last captured request
// ----------------------------------------------------------------------
`include "store_unit_settings.svh"

module store_data_align (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           capture_i,
  input  store_unit_pkg::store_req_t     req_i,
  output logic [`SU_XLEN-1:0]            data_o,
  output logic [`SU_XLEN/8-1:0]          be_o,
  output store_unit_pkg::size_e          size_o,
  output logic [`SU_TRANS_ID_BITS-1:0]   trans_id_o
);

  logic [2*`SU_XLEN-1:0] data_dbl;
  logic [5:0]            shamt;
  logic [`SU_XLEN-1:0]   data_rot;

  // Rotate left by 8 * offset, upper half of the shifted double word
  assign shamt    = {req_i.vaddr[2:0], 3'b000};
  assign data_dbl = {req_i.data, req_i.data} << shamt;
  assign data_rot = data_dbl[2*`SU_XLEN-1:`SU_XLEN];

  // Payload
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      data_o <= data_rot;
    end
  end

  // Byte enable, size and ID for the second cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      be_o       <= '0;
      size_o     <= store_unit_pkg::SIZE_B;
      trans_id_o <= '0;
    end else if (capture_i) begin
      be_o       <= req_i.be;
      size_o     <= req_i.size;
      trans_id_o <= req_i.trans_id;
    end
  end

endmodule

// File: store_buffer.sv
// ----------------------------------------------------------------------
// Store buffer with a speculative and a commit queue
// commit_i is expected only while commit_ready_o is high and a
// speculative entry exists; both are checked again here
// Flush empties the speculative queue, committed stores still drain
// ----------------------------------------------------------------------
`include "store_unit_settings.svh"

module store_buffer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         st_valid_i,
  input  logic                         st_valid_nf_i,
  input  logic                         commit_i,
  input  logic                         mem_gnt_i,
  input  store_unit_pkg::store_entry_t entry_i,
  input  logic [11:0]                  page_offset_i,
  output logic                         st_ready_o,
  output logic                         commit_ready_o,
  output logic                         mem_req_o,
  output store_unit_pkg::mem_wr_t      mem_wr_o,
  output logic                         page_offset_matches_o,
  output logic                         store_buffer_empty_o,
  output logic                         no_st_pending_o
);

  localparam int unsigned SPEC_DEPTH   = `SU_SPEC_DEPTH;
  localparam int unsigned COMMIT_DEPTH = `SU_COMMIT_DEPTH;
  localparam int unsigned SPEC_AW      = $clog2(SPEC_DEPTH);
  localparam int unsigned COMMIT_AW    = $clog2(COMMIT_DEPTH);

  store_unit_pkg::store_entry_t spec_mem   [SPEC_DEPTH];
  store_unit_pkg::store_entry_t commit_mem [COMMIT_DEPTH];

  logic [SPEC_AW-1:0]   spec_wr_ptr, spec_rd_ptr, spec_used;
  logic [COMMIT_AW-1:0] commit_wr_ptr, commit_rd_ptr, commit_used;
  logic                 spec_full, spec_empty, commit_full, commit_empty;
  logic                 commit_move, mem_pop;

  // ------------------------------------------------------------------
  // Queue control
  // ------------------------------------------------------------------
  // Head moves only when there is something to move and room for it
  assign commit_move = commit_i && !spec_empty && !commit_full;
  assign mem_pop     = mem_gnt_i && mem_req_o;

  store_queue_cnt #(.DEPTH(SPEC_DEPTH)) u_spec_cnt (
    .clk_i,
    .rst_ni,
    .clear_i (flush_i),
    .push_i  (st_valid_i),
    .pop_i   (commit_move),
    .wr_ptr_o(spec_wr_ptr),
    .rd_ptr_o(spec_rd_ptr),
    .full_o  (spec_full),
    .empty_o (spec_empty)
  );

  store_queue_cnt #(.DEPTH(COMMIT_DEPTH)) u_commit_cnt (
    .clk_i,
    .rst_ni,
    .clear_i (1'b0),
    .push_i  (commit_move),
    .pop_i   (mem_pop),
    .wr_ptr_o(commit_wr_ptr),
    .rd_ptr_o(commit_rd_ptr),
    .full_o  (commit_full),
    .empty_o (commit_empty)
  );

  // Entries held, wraps to zero when full
  assign spec_used   = spec_wr_ptr - spec_rd_ptr;
  assign commit_used = commit_wr_ptr - commit_rd_ptr;

  // Store in VALID_STORE still has to land, so one slot must stay free
  assign st_ready_o     = !spec_full && !(st_valid_nf_i && (spec_used == '1));
  assign commit_ready_o = !commit_full;

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (st_valid_i) begin
      spec_mem[spec_wr_ptr] <= entry_i;
    end
    if (commit_move) begin
      commit_mem[commit_wr_ptr] <= spec_mem[spec_rd_ptr];
    end
  end

  // ------------------------------------------------------------------
  // Memory port and status
  // ------------------------------------------------------------------
  assign mem_req_o      = !commit_empty;
  assign mem_wr_o.paddr = commit_mem[commit_rd_ptr].paddr;
  assign mem_wr_o.data  = commit_mem[commit_rd_ptr].data;
  assign mem_wr_o.be    = commit_mem[commit_rd_ptr].be;

  assign store_buffer_empty_o = spec_empty && commit_empty;
  assign no_st_pending_o      = commit_empty;

  // Double-word match against every live entry and the one in flight
  always_comb begin : page_offset_cmp
    logic [SPEC_AW-1:0]   spec_rel;
    logic [COMMIT_AW-1:0] commit_rel;
    page_offset_matches_o = st_valid_nf_i && (entry_i.paddr[11:3] == page_offset_i[11:3]);
    for (int unsigned i = 0; i < SPEC_DEPTH; i++) begin
      spec_rel = SPEC_AW'(i) - spec_rd_ptr;
      if ((spec_full || (spec_rel < spec_used)) &&
          (spec_mem[i].paddr[11:3] == page_offset_i[11:3])) begin
        page_offset_matches_o = 1'b1;
      end
    end
    for (int unsigned i = 0; i < COMMIT_DEPTH; i++) begin
      commit_rel = COMMIT_AW'(i) - commit_rd_ptr;
      if ((commit_full || (commit_rel < commit_used)) &&
          (commit_mem[i].paddr[11:3] == page_offset_i[11:3])) begin
        page_offset_matches_o = 1'b1;
      end
    end
  end

endmodule

// File: store_unit.sv
// ----------------------------------------------------------------------
// Store unit top level
// paddr_i and ex_i must describe the store in its second cycle
// The result carries the aligned store data, stores return no value
// ----------------------------------------------------------------------
`include "store_unit_settings.svh"

module store_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          valid_i,
  input  logic                          dtlb_hit_i,
  input  logic                          commit_i,
  input  logic                          mem_gnt_i,
  input  store_unit_pkg::store_req_t    req_i,
  input  logic [`SU_PLEN-1:0]           paddr_i,
  input  store_unit_pkg::store_ex_t     ex_i,
  input  logic [11:0]                   page_offset_i,
  output logic                          pop_st_o,
  output logic                          valid_o,
  output logic                          translation_req_o,
  output logic [`SU_VLEN-1:0]           vaddr_o,
  output store_unit_pkg::store_result_t result_o,
  output logic                          commit_ready_o,
  output logic                          mem_req_o,
  output store_unit_pkg::mem_wr_t       mem_wr_o,
  output logic                          page_offset_matches_o,
  output logic                          store_buffer_empty_o,
  output logic                          no_st_pending_o
);

  logic                         st_ready, st_valid, st_valid_nf, capture;
  logic [`SU_XLEN-1:0]          st_data;
  logic [`SU_XLEN/8-1:0]        st_be;
  store_unit_pkg::size_e        st_size;
  logic [`SU_TRANS_ID_BITS-1:0] st_trans_id;
  store_unit_pkg::store_entry_t st_entry;

  assign vaddr_o = req_i.vaddr;

  store_ctrl_fsm u_ctrl (
    .clk_i,
    .rst_ni,
    .flush_i,
    .valid_i,
    .dtlb_hit_i,
    .ex_valid_i       (ex_i.valid),
    .st_ready_i       (st_ready),
    .pop_st_o,
    .valid_o,
    .translation_req_o,
    .st_valid_o       (st_valid),
    .st_valid_nf_o    (st_valid_nf),
    .capture_o        (capture)
  );

  store_data_align u_align (
    .clk_i,
    .rst_ni,
    .capture_i (capture),
    .req_i,
    .data_o    (st_data),
    .be_o      (st_be),
    .size_o    (st_size),
    .trans_id_o(st_trans_id)
  );

  // Second-cycle entry, address straight from translation
  assign st_entry = '{paddr: paddr_i, data: st_data, be: st_be, size: st_size};

  // Result for the issue stage
  assign result_o = '{trans_id: st_trans_id, result: st_data, ex: ex_i};

  store_buffer u_buffer (
    .clk_i,
    .rst_ni,
    .flush_i,
    .st_valid_i    (st_valid),
    .st_valid_nf_i (st_valid_nf),
    .commit_i,
    .mem_gnt_i,
    .entry_i       (st_entry),
    .page_offset_i,
    .st_ready_o    (st_ready),
    .commit_ready_o,
    .mem_req_o,
    .mem_wr_o,
    .page_offset_matches_o,
    .store_buffer_empty_o,
    .no_st_pending_o
  );

endmodule

// File: store_unit_checker.sv
// ----------------------------------------------------------------------
// Concurrent assertions bound to the store unit top level
// All but the reset check are off while rst_ni is low
// ----------------------------------------------------------------------
module store_unit_checker (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      flush_i,
  input logic                      dtlb_hit_i,
  input store_unit_pkg::store_ex_t ex_i,
  input logic                      pop_st_o,
  input logic                      valid_o,
  input logic                      mem_req_o,
  input logic                      store_buffer_empty_o
);

  int unsigned fail_cnt;

  initial fail_cnt = 0;

  // Only an exception may pop without a TLB hit
  pop_needs_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop_st_o && !ex_i.valid) |-> dtlb_hit_i)
    else begin
      fail_cnt++;
      $error("pop_st_o high while dtlb_hit_i is low");
    end

  // Regular pop gets its result one cycle later
  pop_then_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop_st_o && !ex_i.valid && !flush_i) |=> valid_o)
    else begin
      fail_cnt++;
      $error("valid_o missing one cycle after pop_st_o");
    end

  // Result only after a pop or with an exception
  valid_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> ($past(pop_st_o) || ex_i.valid))
    else begin
      fail_cnt++;
      $error("valid_o without a preceding pop or an exception");
    end

  // Out of reset nothing goes to memory
  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!mem_req_o && store_buffer_empty_o))
    else begin
      fail_cnt++;
      $error("memory request or stored entry right after reset");
    end

endmodule

bind store_unit store_unit_checker u_checker (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .flush_i             (flush_i),
  .dtlb_hit_i          (dtlb_hit_i),
  .ex_i                (ex_i),
  .pop_st_o            (pop_st_o),
  .valid_o             (valid_o),
  .mem_req_o           (mem_req_o),
  .store_buffer_empty_o(store_buffer_empty_o)
);

// File: tb_store_unit.sv
// ----------------------------------------------------------------------
// Testbench for the store unit
// Inputs change on the falling edge, outputs are sampled 1 unit later
// Exceptions are raised only in the cycle after an accepted store
// Grants are withheld for a stretch to fill both queues
// ----------------------------------------------------------------------
`include "store_unit_settings.svh"

module tb_store_unit;

  localparam int NUM_CYCLES = 3000;
  localparam int HOLD_START = 1000;
  localparam int HOLD_LEN   = 100;
  localparam int RST_CYCLES = 5;
  localparam int DRAIN_MAX  = 200;
  localparam int TIMEOUT    = (RST_CYCLES + NUM_CYCLES + DRAIN_MAX) * 4 + 400;

  logic clk_i, rst_ni, flush_i, valid_i, dtlb_hit_i, commit_i, mem_gnt_i;
  store_unit_pkg::store_req_t    req_i;
  logic [`SU_PLEN-1:0]           paddr_i;
  store_unit_pkg::store_ex_t     ex_i;
  logic [11:0]                   page_offset_i;
  logic pop_st_o, valid_o, translation_req_o, commit_ready_o, mem_req_o;
  logic [`SU_VLEN-1:0]           vaddr_o;
  store_unit_pkg::store_result_t result_o;
  store_unit_pkg::mem_wr_t       mem_wr_o;
  logic page_offset_matches_o, store_buffer_empty_o, no_st_pending_o;

  integer seed = 32'h3ef7_e626;

  // Issue side: pending request and the store in its second cycle
  store_unit_pkg::store_req_t   cur_req, fl_req;
  logic [`SU_PLEN-1:0]          cur_paddr, fl_paddr;
  bit                           have_req, waiting, in_flight;
  logic [`SU_TRANS_ID_BITS-1:0] next_id;
  // Model of the two queues
  store_unit_pkg::mem_wr_t      spec_q[$];
  store_unit_pkg::mem_wr_t      commit_q[$];
  int                           bp_cycles;

  store_unit u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(TIMEOUT);
    report_failure("Watchdog expired before the buffer drained");
  end

  // ------------------------------------------------------------------
  // Reporting and compares
  // ------------------------------------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_vaddr(input string name, input logic [`SU_VLEN-1:0] exp,
                             input logic [`SU_VLEN-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_result(input string name, input store_unit_pkg::store_result_t exp,
                              input store_unit_pkg::store_result_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_mem(input string name, input store_unit_pkg::mem_wr_t exp,
                           input store_unit_pkg::mem_wr_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected %h actual %h", name, exp, act));
    end
  endtask

  // Rotate left by whole bytes of the address offset
  function automatic logic [`SU_XLEN-1:0] rotate_data(input logic [`SU_XLEN-1:0] d,
                                                     input logic [2:0] off);
    int unsigned sh;
    sh = 8 * off;
    return (d << sh) | (d >> (`SU_XLEN - sh));
  endfunction

  task automatic make_request();
    cur_req.vaddr       = `SU_VLEN'({$random(seed), $random(seed)});
    // Few distinct double words so that offset matches happen
    cur_req.vaddr[11:3] = 9'({$random(seed)} % 16);
    cur_req.data        = {$random(seed), $random(seed)};
    cur_req.be          = 8'($random(seed));
    cur_req.size        = store_unit_pkg::size_e'(2'($random(seed)));
    cur_req.trans_id    = next_id;
    next_id++;
    // Translation keeps the page offset
    cur_paddr        = `SU_PLEN'({$random(seed), $random(seed)});
    cur_paddr[11:0]  = cur_req.vaddr[11:0];
  endtask

  // ------------------------------------------------------------------
  // One clock cycle: drive, check, advance the model
  // ------------------------------------------------------------------
  task automatic run_cycle(input bit drain, input bit hold);
    store_unit_pkg::store_result_t exp_res;
    store_unit_pkg::mem_wr_t       ent;
    bit                            flush, ex, ready, exp_pop, exp_match;
    @(negedge clk_i);
    flush = !drain && !hold && ({$random(seed)} % 40 == 0);
    ex    = !drain && !hold && !flush && in_flight && ({$random(seed)} % 6 == 0);
    if (flush) begin
      have_req = 1'b0;
    end
    if (!have_req && !drain && !flush && !ex && ({$random(seed)} % 4 != 0)) begin
      make_request();
      have_req = 1'b1;
    end
    flush_i    = flush;
    valid_i    = have_req;
    req_i      = cur_req;
    dtlb_hit_i = ({$random(seed)} % 4 != 0);
    paddr_i    = in_flight ? fl_paddr : cur_paddr;
    ex_i       = '0;
    if (ex) begin
      ex_i.valid = 1'b1;
      // Store page fault
      ex_i.cause = 64'd15;
      ex_i.tval  = 64'(fl_req.vaddr);
    end
    commit_i = !flush && (spec_q.size() > 0) && (commit_q.size() < `SU_COMMIT_DEPTH) &&
               (drain || ({$random(seed)} % 2 == 0));
    mem_gnt_i     = !hold && (drain || ({$random(seed)} % 3 != 0));
    page_offset_i = {9'({$random(seed)} % 16), 3'($random(seed))};

    // Expected responses for this cycle
    ready     = (spec_q.size() + in_flight) < `SU_SPEC_DEPTH;
    exp_pop   = ex || (!waiting && valid_i && dtlb_hit_i && ready);
    exp_match = in_flight && (fl_paddr[11:3] == page_offset_i[11:3]);
    foreach (spec_q[i]) begin
      if (spec_q[i].paddr[11:3] == page_offset_i[11:3]) begin
        exp_match = 1'b1;
      end
    end
    foreach (commit_q[i]) begin
      if (commit_q[i].paddr[11:3] == page_offset_i[11:3]) begin
        exp_match = 1'b1;
      end
    end
    ent.paddr = fl_paddr;
    ent.data  = rotate_data(fl_req.data, fl_req.vaddr[2:0]);
    ent.be    = fl_req.be;

    #1;
    if (u_dut.u_checker.fail_cnt != 0) begin
      report_failure("A bound assertion failed at the last rising edge");
    end
    check_flag("pop_st_o", exp_pop, pop_st_o);
    check_flag("valid_o", in_flight, valid_o);
    if (in_flight) begin
      exp_res.trans_id = fl_req.trans_id;
      exp_res.result   = ent.data;
      exp_res.ex.valid = ex;
      exp_res.ex.cause = ex ? 64'd15 : 64'd0;
      exp_res.ex.tval  = ex ? 64'(fl_req.vaddr) : 64'd0;
      check_result("result_o", exp_res, result_o);
    end
    check_flag("translation_req_o", waiting || valid_i, translation_req_o);
    if (waiting || valid_i) begin
      check_vaddr("vaddr_o", cur_req.vaddr, vaddr_o);
    end
    check_flag("commit_ready_o", commit_q.size() < `SU_COMMIT_DEPTH, commit_ready_o);
    check_flag("mem_req_o", commit_q.size() != 0, mem_req_o);
    if (commit_q.size() != 0) begin
      check_mem("mem_wr_o", commit_q[0], mem_wr_o);
    end
    check_flag("page_offset_matches_o", exp_match, page_offset_matches_o);
    check_flag("no_st_pending_o", commit_q.size() == 0, no_st_pending_o);
    check_flag("store_buffer_empty_o", (spec_q.size() == 0) && (commit_q.size() == 0),
               store_buffer_empty_o);

    // Queue updates at the coming rising edge
    if (mem_gnt_i && (commit_q.size() != 0)) begin
      void'(commit_q.pop_front());
    end
    if (commit_i) begin
      commit_q.push_back(spec_q.pop_front());
    end
    if (in_flight && !flush && !ex) begin
      spec_q.push_back(ent);
    end
    if (flush) begin
      spec_q.delete();
    end
    if (hold && (commit_q.size() == `SU_COMMIT_DEPTH) && (spec_q.size() == `SU_SPEC_DEPTH)) begin
      bp_cycles++;
    end

    // Control and issue side
    if (flush) begin
      waiting = 1'b0;
    end else if (waiting) begin
      waiting = !(dtlb_hit_i && ready);
    end else begin
      waiting = valid_i && !exp_pop;
    end
    if (exp_pop && !ex) begin
      fl_req   = cur_req;
      fl_paddr = cur_paddr;
      have_req = 1'b0;
    end
    in_flight = exp_pop && !ex && !flush;
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    valid_i       = 1'b0;
    dtlb_hit_i    = 1'b0;
    commit_i      = 1'b0;
    mem_gnt_i     = 1'b0;
    req_i         = '0;
    paddr_i       = '0;
    ex_i          = '0;
    page_offset_i = '0;
    cur_req       = '0;
    fl_req        = '0;
    cur_paddr     = '0;
    fl_paddr      = '0;
    have_req      = 1'b0;
    waiting       = 1'b0;
    in_flight     = 1'b0;
    next_id       = '0;
    bp_cycles     = 0;
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int c = 0; c < NUM_CYCLES; c++) begin
      run_cycle(1'b0, (c >= HOLD_START) && (c < HOLD_START + HOLD_LEN));
    end
    // No new stores, commit and grant everything
    while (have_req || waiting || in_flight || (spec_q.size() != 0) ||
           (commit_q.size() != 0)) begin
      run_cycle(1'b1, 1'b0);
    end
    // Idle cycle, empty flags are checked here
    run_cycle(1'b1, 1'b0);

    if (bp_cycles == 0) begin
      report_failure("Withheld grant never filled both queues");
    end else if (u_dut.u_checker.fail_cnt != 0) begin
      report_failure("Bound assertions failed during the run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// File: vlog.f
+incdir+.
store_unit_pkg.sv
store_queue_cnt.sv
store_ctrl_fsm.sv
store_data_align.sv
store_buffer.sv
store_unit.sv
store_unit_checker.sv
tb_store_unit.sv

// File: Bender.yml
package:
  name: store_unit

export_include_dirs:
  - .

sources:
  - files:
      - store_unit_pkg.sv
      - store_queue_cnt.sv
      - store_ctrl_fsm.sv
      - store_data_align.sv
      - store_buffer.sv
      - store_unit.sv
  - target: simulation
    files:
      - store_unit_checker.sv
      - tb_store_unit.sv
